// File: mapViewerPkg.sv
/*
 * Shared definitions for the scrolling map viewer.
 * Screen and map geometry, camera and player limits, key opcodes,
 * the 16-entry palette and the structs passed between blocks.
 * Other files refer to these by scoped name only.
 */
package mapViewerPkg;

    // ------------------------------------------------------------
    // Raster and window geometry
    // ------------------------------------------------------------
    localparam int coordW = 10;                          // Raster coordinate width

    localparam logic [coordW-1:0] winLeft   = 10'd80;    // Window top-left, screen px
    localparam logic [coordW-1:0] winTop    = 10'd80;
    localparam logic [coordW-1:0] winWidth  = 10'd480;   // 240 map px at 2x
    localparam logic [coordW-1:0] winHeight = 10'd320;   // 160 map px at 2x

    // Camera range in map pixels, minimum is 0 on both axes
    localparam logic [coordW-1:0] camXMax = 10'd240;
    localparam logic [coordW-1:0] camYMax = 10'd160;

    // Player bounds and centre, screen px
    localparam logic [coordW-1:0] playerXMin    = 10'd100;
    localparam logic [coordW-1:0] playerXMax    = 10'd539;
    localparam logic [coordW-1:0] playerYMin    = 10'd100;
    localparam logic [coordW-1:0] playerYMax    = 10'd379;
    localparam logic [coordW-1:0] playerXCenter = 10'd320;
    localparam logic [coordW-1:0] playerYCenter = 10'd240;

    localparam logic [coordW-1:0] spriteHalfW = 10'd6;   // 13 px wide box
    localparam logic [coordW-1:0] spriteHalfH = 10'd10;  // 21 px tall box

    // ------------------------------------------------------------
    // Map cells and palette
    // ------------------------------------------------------------
    localparam int cellShift     = 4;                    // 16x16 map px per cell
    localparam int cellAddrW     = 10;
    localparam int paletteIndexW = 4;

    localparam logic [cellAddrW-1:0] mapCols = 10'd30;
    localparam logic [cellAddrW-1:0] mapRows = 10'd20;

    // Key opcodes, USB HID usage codes
    typedef enum logic [7:0] {
        keyA = 8'h04,
        keyD = 8'h07,
        keyS = 8'h16,
        keyW = 8'h1A
    } keyOp_e;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [coordW-1:0] camX;      // Map px, window left edge
        logic [coordW-1:0] camY;      // Map px, window top edge
        logic [coordW-1:0] playerX;   // Screen px, sprite centre
        logic [coordW-1:0] playerY;
    } viewState_t;

    typedef struct packed {
        logic                 inWindow;
        logic                 inSprite;
        logic [cellAddrW-1:0] cellAddr;
    } pixelInfo_t;

    localparam rgb_t spriteColor = '{red: 8'hFF, green: 8'h55, blue: 8'h00};

    // 4 bits per channel, {r, g, b}
    localparam logic [11:0] paletteTable [16] = '{
        12'h000, 12'h4A3, 12'h6C4, 12'h283,   // Black, grass shades
        12'hDC8, 12'hB96, 12'h37D, 12'h5AF,   // Path, sand, water
        12'h964, 12'h642, 12'hC33, 12'hEEE,   // Wood, roof, wall
        12'h888, 12'h555, 12'hFD5, 12'h2B8    // Stone, flowers
    };

endpackage

// File: motionControl.sv
/*
 * Key decoding and camera / player motion.
 * Both key bytes are decoded into per-axis directions. On each
 * frameTick the camera scrolls while the player is centred, and the
 * player walks, clamped to its bounds, once the camera hits a limit.
 */
module motionControl (
    input  logic                     Clock,
    input  logic                     Reset,
    input  logic                     frameTick,
    input  logic [15:0]              keycode,
    output mapViewerPkg::viewState_t viewState
);

    logic moveLeft, moveRight, moveUp, moveDown;   // Raw key presence
    logic negX, posX, negY, posY;                  // After cancelling opposites
    logic [mapViewerPkg::coordW-1:0] camXNext, camYNext;
    logic [mapViewerPkg::coordW-1:0] playerXNext, playerYNext;

    // ------------------------------------------------------------
    // Key decode, either byte may hold any key
    // ------------------------------------------------------------
    always_comb begin
        moveLeft  = 1'b0;
        moveRight = 1'b0;
        moveUp    = 1'b0;
        moveDown  = 1'b0;
        for (int i = 0; i < 2; i++) begin
            case (keycode[8*i +: 8])
                mapViewerPkg::keyA: moveLeft  = 1'b1;
                mapViewerPkg::keyD: moveRight = 1'b1;
                mapViewerPkg::keyW: moveUp    = 1'b1;
                mapViewerPkg::keyS: moveDown  = 1'b1;
                default: ;                             // Unknown key, no motion
            endcase
        end
        negX = moveLeft & ~moveRight;                  // A+D cancels
        posX = moveRight & ~moveLeft;
        negY = moveUp & ~moveDown;                     // W+S cancels
        posY = moveDown & ~moveUp;
    end

    // One axis of the motion rule, same for x and y
    function automatic void stepAxis(
        input  logic                            neg,
        input  logic                            pos,
        input  logic [mapViewerPkg::coordW-1:0] cam,
        input  logic [mapViewerPkg::coordW-1:0] camMax,
        input  logic [mapViewerPkg::coordW-1:0] player,
        input  logic [mapViewerPkg::coordW-1:0] center,
        input  logic [mapViewerPkg::coordW-1:0] playerMin,
        input  logic [mapViewerPkg::coordW-1:0] playerMax,
        output logic [mapViewerPkg::coordW-1:0] camNext,
        output logic [mapViewerPkg::coordW-1:0] playerNext
    );
        logic camFree;
        camFree = (player == center) &&
                  ((neg && (cam != '0)) || (pos && (cam < camMax)));
        camNext    = cam;
        playerNext = player;
        if (camFree) begin
            camNext = neg ? cam - 1'b1 : cam + 1'b1;   // Scroll
        end else if (neg && (player > playerMin)) begin
            playerNext = player - 1'b1;                // Walk, clamped low
        end else if (pos && (player < playerMax)) begin
            playerNext = player + 1'b1;                // Walk, clamped high
        end
    endfunction

    always_comb begin
        stepAxis(negX, posX, viewState.camX, mapViewerPkg::camXMax,
                 viewState.playerX, mapViewerPkg::playerXCenter,
                 mapViewerPkg::playerXMin, mapViewerPkg::playerXMax,
                 camXNext, playerXNext);
        stepAxis(negY, posY, viewState.camY, mapViewerPkg::camYMax,
                 viewState.playerY, mapViewerPkg::playerYCenter,
                 mapViewerPkg::playerYMin, mapViewerPkg::playerYMax,
                 camYNext, playerYNext);
    end

    // ------------------------------------------------------------
    // Position registers, updated only on the frame tick
    // ------------------------------------------------------------
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            viewState.camX    <= '0;                   // Top-left of map
            viewState.camY    <= '0;
            viewState.playerX <= mapViewerPkg::playerXCenter;
            viewState.playerY <= mapViewerPkg::playerYCenter;
        end else if (frameTick) begin
            viewState.camX    <= camXNext;
            viewState.camY    <= camYNext;
            viewState.playerX <= playerXNext;
            viewState.playerY <= playerYNext;
        end
    end

    // Camera and player never leave their ranges
    assert property (@(posedge Clock) disable iff (Reset)
        (viewState.camX <= mapViewerPkg::camXMax) &&
        (viewState.camY <= mapViewerPkg::camYMax) &&
        (viewState.playerX >= mapViewerPkg::playerXMin) &&
        (viewState.playerX <= mapViewerPkg::playerXMax) &&
        (viewState.playerY >= mapViewerPkg::playerYMin) &&
        (viewState.playerY <= mapViewerPkg::playerYMax))
        else $error("motionControl: position out of range");

    // Player leaves centre only while the camera rests on a limit
    assert property (@(posedge Clock) disable iff (Reset)
        (viewState.camX != '0) && (viewState.camX != mapViewerPkg::camXMax)
        |-> (viewState.playerX == mapViewerPkg::playerXCenter))
        else $error("motionControl: camera x scrolled with player off centre");

    assert property (@(posedge Clock) disable iff (Reset)
        (viewState.camY != '0) && (viewState.camY != mapViewerPkg::camYMax)
        |-> (viewState.playerY == mapViewerPkg::playerYCenter))
        else $error("motionControl: camera y scrolled with player off centre");

endmodule

// File: pixelLocator.sv
/*
 * Pixel pipeline stage 1.
 * Tests the raster position against the map window and the sprite box
 * and turns it into a map cell address. Results and the display
 * enable are registered together, one cycle of latency.
 */
module pixelLocator (
    input  logic                              Clock,
    input  logic                              Reset,
    input  logic                              displayEnable,
    input  logic [mapViewerPkg::coordW-1:0]   drawX,
    input  logic [mapViewerPkg::coordW-1:0]   drawY,
    input  mapViewerPkg::viewState_t          viewState,
    output mapViewerPkg::pixelInfo_t          pixelInfo,
    output logic                              enableOut
);

    logic inWindow, inSprite;
    logic [mapViewerPkg::coordW-1:0]    offsetX, offsetY;   // Screen px inside window
    logic [mapViewerPkg::coordW-1:0]    mapX, mapY;         // Map px
    logic [mapViewerPkg::cellAddrW-1:0] cellCol, cellRow, cellAddr;

    always_comb begin
        inWindow = (drawX >= mapViewerPkg::winLeft) &&
                   (drawX <  mapViewerPkg::winLeft + mapViewerPkg::winWidth) &&
                   (drawY >= mapViewerPkg::winTop) &&
                   (drawY <  mapViewerPkg::winTop + mapViewerPkg::winHeight);

        // Box around centre, written without negative offsets
        inSprite = (drawX + mapViewerPkg::spriteHalfW >= viewState.playerX) &&
                   (drawX <= viewState.playerX + mapViewerPkg::spriteHalfW) &&
                   (drawY + mapViewerPkg::spriteHalfH >= viewState.playerY) &&
                   (drawY <= viewState.playerY + mapViewerPkg::spriteHalfH);

        offsetX = drawX - mapViewerPkg::winLeft;
        offsetY = drawY - mapViewerPkg::winTop;
        mapX    = viewState.camX + (offsetX >> 1);          // 2x scale
        mapY    = viewState.camY + (offsetY >> 1);
        cellCol = mapX >> mapViewerPkg::cellShift;
        cellRow = mapY >> mapViewerPkg::cellShift;

        // Outside the window the address is parked at 0
        cellAddr = inWindow ? (cellRow * mapViewerPkg::mapCols + cellCol) : '0;
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pixelInfo <= '0;
            enableOut <= 1'b0;
        end else begin
            pixelInfo <= '{inWindow: inWindow, inSprite: inSprite, cellAddr: cellAddr};
            enableOut <= displayEnable;
        end
    end

    // Window pixels always land inside the cell grid
    assert property (@(posedge Clock) disable iff (Reset)
        pixelInfo.inWindow |->
            (pixelInfo.cellAddr < mapViewerPkg::mapCols * mapViewerPkg::mapRows))
        else $error("pixelLocator: cell address %0d past end of map", pixelInfo.cellAddr);

endmodule

// File: mapRom.sv
/*
 * Pixel pipeline stage 2.
 * Cell ROM of 30x20 palette indices, filled from mapCells.hex at
 * start-up. Synchronous read, data valid one cycle after the address.
 */
module mapRom (
    input  logic                                  Clock,
    input  logic [mapViewerPkg::cellAddrW-1:0]    cellAddr,
    output logic [mapViewerPkg::paletteIndexW-1:0] paletteIndex
);

    // Row-major, 30 cells per row
    logic [mapViewerPkg::paletteIndexW-1:0] cells [mapViewerPkg::mapCols * mapViewerPkg::mapRows];

    initial begin
        $readmemh("mapCells.hex", cells);
    end

    always_ff @(posedge Clock) begin
        paletteIndex <= cells[cellAddr];   // Block RAM style read
    end

endmodule

// File: colorOutput.sv
/*
 * Pixel pipeline stage 3.
 * Realigns the stage-1 flags with the ROM data, looks up the palette
 * and picks sprite, map or black. The RGB register clears to black.
 */
module colorOutput (
    input  logic                                   Clock,
    input  logic                                   Reset,
    input  mapViewerPkg::pixelInfo_t               pixelInfo,
    input  logic                                   enableIn,
    input  logic [mapViewerPkg::paletteIndexW-1:0] paletteIndex,
    output mapViewerPkg::rgb_t                     rgb
);

    mapViewerPkg::pixelInfo_t infoDly;     // Matches ROM latency
    logic                     enableDly;
    logic [11:0]              paletteColor;
    mapViewerPkg::rgb_t       rgbNext;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            infoDly   <= '0;
            enableDly <= 1'b0;
        end else begin
            infoDly   <= pixelInfo;
            enableDly <= enableIn;
        end
    end

    // Colour priority, sprite over map over black
    always_comb begin
        paletteColor = mapViewerPkg::paletteTable[paletteIndex];
        if (!enableDly) begin
            rgbNext = '0;                                  // Blanking
        end else if (infoDly.inSprite) begin
            rgbNext = mapViewerPkg::spriteColor;
        end else if (infoDly.inWindow) begin
            rgbNext.red   = {paletteColor[11:8], 4'h0};    // Nibble to top of byte
            rgbNext.green = {paletteColor[7:4], 4'h0};
            rgbNext.blue  = {paletteColor[3:0], 4'h0};
        end else begin
            rgbNext = '0;                                  // Border
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            rgb <= '0;
        end else begin
            rgb <= rgbNext;
        end
    end

endmodule

// File: mapViewer.sv
/*
 * Scrolling map viewer, top level.
 * Motion control feeds the camera and player state into a three-stage
 * pixel pipeline: locate, cell ROM read, colour out. One pixel per
 * clock, frameTick pulses once per frame to apply the keys.
 */
module mapViewer (
    input  logic                            Clock,
    input  logic                            Reset,
    input  logic [mapViewerPkg::coordW-1:0] drawX,
    input  logic [mapViewerPkg::coordW-1:0] drawY,
    input  logic                            displayEnable,
    input  logic [15:0]                     keycode,
    input  logic                            frameTick,
    output mapViewerPkg::rgb_t              rgb,
    output mapViewerPkg::viewState_t        viewState
);

    mapViewerPkg::pixelInfo_t               pixelInfo;     // Stage 1 out
    logic                                   enableStage1;
    logic [mapViewerPkg::paletteIndexW-1:0] paletteIndex;  // Stage 2 out

    // ------------------------------------------------------------
    // Position control
    // ------------------------------------------------------------
    motionControl motion (
        .Clock     (Clock),
        .Reset     (Reset),
        .frameTick (frameTick),
        .keycode   (keycode),
        .viewState (viewState)
    );

    // ------------------------------------------------------------
    // Pixel pipeline
    // ------------------------------------------------------------
    pixelLocator locator (
        .Clock         (Clock),
        .Reset         (Reset),
        .displayEnable (displayEnable),
        .drawX         (drawX),
        .drawY         (drawY),
        .viewState     (viewState),
        .pixelInfo     (pixelInfo),
        .enableOut     (enableStage1)
    );

    mapRom cellRom (
        .Clock        (Clock),
        .cellAddr     (pixelInfo.cellAddr),
        .paletteIndex (paletteIndex)
    );

    colorOutput colorStage (
        .Clock        (Clock),
        .Reset        (Reset),
        .pixelInfo    (pixelInfo),
        .enableIn     (enableStage1),
        .paletteIndex (paletteIndex),
        .rgb          (rgb)
    );

endmodule

// File: mapViewerChecker.sv
/*
 * Scoreboard for the map viewer testbench.
 * Watches the DUT ports, runs its own camera and player model and
 * predicts every pixel's colour three clocks ahead. Compares at the
 * falling edge and counts rgb and viewState mismatches.
 */
module mapViewerChecker (
    input  logic                            Clock,
    input  logic                            Reset,
    input  logic [mapViewerPkg::coordW-1:0] drawX,
    input  logic [mapViewerPkg::coordW-1:0] drawY,
    input  logic                            displayEnable,
    input  logic [15:0]                     keycode,
    input  logic                            frameTick,
    input  mapViewerPkg::rgb_t              rgb,
    input  mapViewerPkg::viewState_t        viewState,
    output int                              rgbErrors,
    output int                              stateErrors,
    output int                              checkCount
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [mapViewerPkg::coordW-1:0] x;
        logic [mapViewerPkg::coordW-1:0] y;
        mapViewerPkg::rgb_t              color;
    } expect_t;

    logic [mapViewerPkg::paletteIndexW-1:0] cellMem [600];   // Own copy of the map
    expect_t pending [$];                                      // Predictions in flight
    int camX, camY, playerX, playerY;                          // Motion model

    initial begin
        $readmemh("mapCells.hex", cellMem);
    end

    // Signed step from both key bytes with opposites cancelling
    function automatic int keyDir(input logic [15:0] keys, input mapViewerPkg::keyOp_e negKey,
                                  input mapViewerPkg::keyOp_e posKey);
        logic hasNeg;
        logic hasPos;
        hasNeg = (keys[15:8] == negKey) || (keys[7:0] == negKey);
        hasPos = (keys[15:8] == posKey) || (keys[7:0] == posKey);
        return int'(hasPos) - int'(hasNeg);
    endfunction

    // Scroll the camera when possible and otherwise walk the player
    function automatic void advanceAxis(
        input  int d,
        input  int camLimit,
        input  int lo,
        input  int hi,
        input  int centre,
        input  int camNow,
        input  int posNow,
        output int camNew,
        output int posNew
    );
        int wanted;
        wanted = camNow + d;
        camNew = camNow;
        posNew = posNow;
        if (posNow == centre && wanted >= 0 && wanted <= camLimit)
            camNew = wanted;
        else
            posNew = (posNow + d < lo) ? lo : ((posNow + d > hi) ? hi : posNow + d);
    endfunction

    function automatic mapViewerPkg::rgb_t predictColor(input int x, input int y, input logic en);
        int mapX;
        int mapY;
        logic [11:0] pal;
        mapViewerPkg::rgb_t color;
        color = '0;                                          // Border and blanking
        mapX = camX + (x - 80) / 2;                          // 2x scale from window corner
        mapY = camY + (y - 80) / 2;
        if (en && x >= playerX - 6 && x <= playerX + 6 && y >= playerY - 10 &&
            y <= playerY + 10) begin
            color = mapViewerPkg::spriteColor;
        end else if (en && x >= 80 && x < 560 && y >= 80 && y < 400) begin
            pal = mapViewerPkg::paletteTable[cellMem[(mapY / 16) * 30 + mapX / 16]];
            color = {pal[11:8], 4'h0, pal[7:4], 4'h0, pal[3:0], 4'h0};
        end
        return color;
    endfunction

    task automatic compareField(input string name, input logic [9:0] actual, input int expected);
        if (actual !== 10'(expected)) begin
            stateErrors++;
            $display("ERROR %s: expected %h, got %h", name, 10'(expected), actual);
        end
    endtask

    // ------------------------------------------------------------
    // Predict at the rising edge from the state before the tick
    // ------------------------------------------------------------
    always @(posedge Clock) begin
        expect_t entry;
        if (Reset) begin
            camX = 0;
            camY = 0;
            playerX = int'(mapViewerPkg::playerXCenter);
            playerY = int'(mapViewerPkg::playerYCenter);
            pending.delete();
        end else begin
            entry.x = drawX;
            entry.y = drawY;
            entry.color = predictColor(int'(drawX), int'(drawY), displayEnable);
            pending.push_back(entry);
            if (frameTick) begin
                advanceAxis(keyDir(keycode, mapViewerPkg::keyA, mapViewerPkg::keyD),
                            int'(mapViewerPkg::camXMax), int'(mapViewerPkg::playerXMin),
                            int'(mapViewerPkg::playerXMax), int'(mapViewerPkg::playerXCenter),
                            camX, playerX, camX, playerX);
                advanceAxis(keyDir(keycode, mapViewerPkg::keyW, mapViewerPkg::keyS),
                            int'(mapViewerPkg::camYMax), int'(mapViewerPkg::playerYMin),
                            int'(mapViewerPkg::playerYMax), int'(mapViewerPkg::playerYCenter),
                            camY, playerY, camY, playerY);
            end
        end
    end

    // Compare at the falling edge where DUT outputs are settled
    always @(negedge Clock) begin
        expect_t due;
        if (Reset) begin
            rgbErrors = 0;
            stateErrors = 0;
            checkCount = 0;
        end else begin
            if (pending.size() >= 3) begin                   // Pixel sampled two edges back
                due = pending.pop_front();
                checkCount++;
                if (rgb !== due.color) begin
                    rgbErrors++;
                    $display("ERROR rgb at (%0d,%0d): expected %h, got %h",
                             due.x, due.y, due.color, rgb);
                end
            end
            compareField("viewState.camX", viewState.camX, camX);
            compareField("viewState.camY", viewState.camY, camY);
            compareField("viewState.playerX", viewState.playerX, playerX);
            compareField("viewState.playerY", viewState.playerY, playerY);
        end
    end

endmodule

// File: mapViewerTb.sv
/*
 * Testbench for the scrolling map viewer.
 * Each table row sets the keys, pulses frameTick a number of times,
 * then probes three pixels back to back plus one blanked pixel.
 * A burst of random probes follows. mapViewerChecker does the comparing.
 */
module mapViewerTb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [15:0] keys;       // Two key bytes
        logic [9:0]  ticks;
        logic [9:0]  x0;
        logic [9:0]  y0;
        logic [9:0]  x1;
        logic [9:0]  y1;
        logic [9:0]  x2;
        logic [9:0]  y2;
    } step_t;

    // ------------------------------------------------------------
    // Stimulus table with probes around the sprite and window
    // ------------------------------------------------------------
    localparam step_t stepTable [11] = '{
        '{16'h0000, 10'd0,   10'd200, 10'd150, 10'd10,  10'd10,  10'd320, 10'd240},
        '{16'h0007, 10'd20,  10'd81,  10'd81,  10'd300, 10'd200, 10'd326, 10'd250},
        '{16'h0400, 10'd20,  10'd559, 10'd399, 10'd560, 10'd399, 10'd327, 10'd240},
        '{16'h0004, 10'd230, 10'd100, 10'd240, 10'd94,  10'd230, 10'd120, 10'd300},
        '{16'h0007, 10'd230, 10'd320, 10'd240, 10'd79,  10'd80,  10'd400, 10'd120},
        '{16'h1A07, 10'd30,  10'd320, 10'd210, 10'd320, 10'd221, 10'd450, 10'd350},
        '{16'h071A, 10'd5,   10'd320, 10'd205, 10'd200, 10'd396, 10'd500, 10'd90},
        '{16'h0407, 10'd10,  10'd320, 10'd205, 10'd140, 10'd160, 10'd639, 10'd479},
        '{16'h0016, 10'd200, 10'd320, 10'd245, 10'd80,  10'd80,  10'd300, 10'd390},
        '{16'h0007, 10'd250, 10'd375, 10'd245, 10'd368, 10'd235, 10'd530, 10'd380},
        '{16'h0000, 10'd0,   10'd100, 10'd100, 10'd240, 10'd320, 10'd0,   10'd0}
    };

    logic Clock, Reset, displayEnable, frameTick;
    logic [9:0]  drawX, drawY;
    logic [15:0] keycode;
    mapViewerPkg::rgb_t       rgb;
    mapViewerPkg::viewState_t viewState;
    int rgbErrors, stateErrors, checkCount;
    int timeouts;
    int seed;

    mapViewer dut (.Clock(Clock), .Reset(Reset), .drawX(drawX), .drawY(drawY),
                   .displayEnable(displayEnable), .keycode(keycode), .frameTick(frameTick),
                   .rgb(rgb), .viewState(viewState));

    mapViewerChecker scoreboard (.Clock(Clock), .Reset(Reset), .drawX(drawX), .drawY(drawY),
                                 .displayEnable(displayEnable), .keycode(keycode),
                                 .frameTick(frameTick), .rgb(rgb), .viewState(viewState),
                                 .rgbErrors(rgbErrors), .stateErrors(stateErrors),
                                 .checkCount(checkCount));

    always #4 Clock = ~Clock;                                  // 8 ns period

    task automatic pulseTicks(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge Clock);
            frameTick = 1'b1;
            @(negedge Clock);
            frameTick = 1'b0;                                  // Gap between ticks
        end
    endtask

    task automatic driveProbe(input logic [9:0] x, input logic [9:0] y, input logic en);
        @(negedge Clock);
        drawX = x;
        drawY = y;
        displayEnable = en;
    endtask

    // Last probe is sampled at the next edge and checked on the third falling edge
    task automatic waitForChecks();
        int goal;
        int cycles;
        @(posedge Clock);
        goal = checkCount + 3;
        cycles = 0;
        while (checkCount < goal && cycles < 12) begin
            @(posedge Clock);
            cycles++;
        end
        if (checkCount < goal) begin
            $display("Timeout: pixel checks stopped advancing after %0d cycles", cycles);
            timeouts++;
        end
    endtask

    initial begin
        logic [9:0] rx;
        logic [9:0] ry;
        Clock = 1'b0;
        Reset = 1'b1;
        drawX = '0;
        drawY = '0;
        displayEnable = 1'b0;
        keycode = '0;
        frameTick = 1'b0;
        timeouts = 0;
        seed = 32'h901a_d120;
        repeat (3) @(negedge Clock);
        Reset = 1'b0;

        for (int i = 0; i < 11; i++) begin
            @(negedge Clock);
            keycode = stepTable[i].keys;
            pulseTicks(int'(stepTable[i].ticks));
            driveProbe(stepTable[i].x0, stepTable[i].y0, 1'b1);   // Back to back
            driveProbe(stepTable[i].x1, stepTable[i].y1, 1'b1);
            driveProbe(stepTable[i].x2, stepTable[i].y2, 1'b1);
            driveProbe(stepTable[i].x0, stepTable[i].y0, 1'b0);   // Same pixel blanked
            waitForChecks();
        end

        // Random pixels across the whole raster with every fifth one blanked
        for (int i = 0; i < 16; i++) begin
            rx = 10'($unsigned($random(seed)) % 640);
            ry = 10'($unsigned($random(seed)) % 480);
            driveProbe(rx, ry, (i % 5) != 4);
        end
        waitForChecks();

        $display("Error counts: rgb %0d, viewState %0d, timeouts %0d",
                 rgbErrors, stateErrors, timeouts);
        if (rgbErrors + stateErrors + timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: mapCells.hex
// Map cell grid, 20 rows of 30 columns, row-major
// Each value is one 4-bit palette index (one hex digit per cell)
B B B B B B B B B B  B B B B B B B B B B  B B B B B B B B B B
B 1 1 2 1 3 1 1 2 1  1 4 4 1 2 1 1 3 1 1  2 1 6 6 7 6 1 2 1 B
B 1 E 1 1 2 1 3 1 F  1 4 4 1 1 2 1 1 1 3  1 6 7 7 7 6 6 1 2 B
B 2 1 1 A A A 1 1 1  2 4 4 1 1 1 E 1 2 1  1 6 7 7 7 7 6 1 1 B
B 1 1 1 A 8 A 1 2 1  1 4 4 4 4 4 4 4 4 4  1 1 6 7 7 6 1 3 1 B
B 3 1 1 9 8 9 1 1 2  1 4 4 1 1 2 1 1 1 4  1 2 1 6 6 1 1 1 2 B
B 1 2 1 1 4 1 1 3 1  1 4 4 1 C C C 1 1 4  1 1 1 1 1 2 1 E 1 B
B 1 1 4 4 4 4 4 4 4  4 4 4 1 C D C 1 2 4  4 4 4 4 4 4 1 1 1 B
B 2 1 4 1 1 1 2 1 1  1 5 5 1 C C C 1 1 1  1 1 2 1 1 4 1 2 1 B
B 1 1 4 1 F 1 1 1 2  5 5 5 5 1 1 1 3 1 1  2 1 1 1 1 4 1 1 3 B
B 1 3 4 1 1 1 6 6 6  5 5 5 5 5 1 1 1 1 2  1 1 A A 1 4 1 1 1 B
B 1 1 4 1 2 6 7 7 7  6 5 5 5 1 1 2 1 1 1  1 1 A 8 1 4 1 2 1 B
B 2 1 4 1 1 6 7 7 7  7 6 5 1 1 E 1 1 3 1  1 1 9 9 1 4 1 1 1 B
B 1 1 4 1 1 1 6 7 7  6 1 1 1 2 1 1 1 1 1  4 4 4 4 4 4 1 3 1 B
B 1 2 4 4 4 4 4 4 4  4 4 4 4 4 4 4 4 4 4  4 1 1 2 1 1 1 1 1 B
B 1 1 1 1 2 1 1 D 1  1 1 3 1 1 2 1 D 1 1  1 E 1 1 D 1 1 2 1 B
B 3 1 C C 1 1 2 1 1  F 1 1 1 C C 1 1 2 1  1 1 1 3 1 1 C C 1 B
B 1 1 C D 1 2 1 1 1  1 1 2 1 C D 1 1 1 1  2 1 1 1 1 2 C D 1 B
B 1 2 1 1 1 1 3 1 2  1 1 1 1 2 1 1 3 1 1  1 2 1 1 3 1 1 1 2 B
B B B B B B B B B B  B B B B B B B B B B  B B B B B B B B B B

// File: mapViewer.f
mapViewerPkg.sv
motionControl.sv
pixelLocator.sv
mapRom.sv
colorOutput.sv
mapViewer.sv
mapViewerChecker.sv
mapViewerTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the map viewer testbench with Verilator.
# Exits non-zero when the simulation log holds the fail message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mapViewerTb \
    -f mapViewer.f -o mapViewerSim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/mapViewerSim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
